// ==== design/rgmii_rx_pkg.sv ====
// rgmii receive hub package: port-id width, pin/byte/beat structs, beat and state enums
package rgmii_rx_pkg;

  // ------------------------------------------------
  // widths
  // ------------------------------------------------

  // port number field in the hub output, up to 8 ports
  localparam int PORT_ID_W = 3;

  // ------------------------------------------------
  // pin and byte level
  // ------------------------------------------------

  // one port's phy receive pins, sampled once per clock
  typedef struct packed {
    logic [3:0] rxd;
    logic       rx_dv;
    logic       rx_er;
  } rgmii_pins_t;

  // assembled byte from the capture block
  typedef struct packed {
    logic       strobe;   // byte completed this cycle
    logic       active;   // rx_dv level
    logic       er;       // rx_er on either nibble
    logic [7:0] data;
  } rx_byte_t;

  // ------------------------------------------------
  // beat level
  // ------------------------------------------------

  typedef enum logic [1:0] {
    BEAT_DATA    = 2'd0,
    BEAT_END_OK  = 2'd1,
    BEAT_END_ERR = 2'd2
  } beat_kind_e;

  // detector output, one per lane
  typedef struct packed {
    logic       valid;
    beat_kind_e kind;
    logic [7:0] data;
  } lane_beat_t;

  // merged output, tagged with the source port
  typedef struct packed {
    logic                 valid;
    beat_kind_e           kind;
    logic [PORT_ID_W-1:0] port;
    logic [7:0]           data;
  } hub_beat_t;

  // ------------------------------------------------
  // fsm states
  // ------------------------------------------------

  typedef enum logic [1:0] {
    DET_IDLE     = 2'd0,
    DET_PREAMBLE = 2'd1,
    DET_PAYLOAD  = 2'd2
  } detect_state_e;

  typedef enum logic {
    MRG_IDLE    = 1'b0,
    MRG_FORWARD = 1'b1
  } merge_state_e;

endpackage

// ==== design/rgmii_nibble_capture.sv ====
// rgmii_nibble_capture: pairs 10/100 nibbles into bytes per port, realigned on rx_dv rise
module rgmii_nibble_capture #(
  parameter int NUM_PORTS = 4
) (
  input  logic                      clock,
  input  logic                      reset,
  input  rgmii_rx_pkg::rgmii_pins_t rx_pins  [NUM_PORTS],
  output rgmii_rx_pkg::rx_byte_t    byte_bus [NUM_PORTS]
);
  import rgmii_rx_pkg::*;

  // ------------------------------------------------
  // per port pairing state
  // ------------------------------------------------
  logic [NUM_PORTS-1:0] phase;      // high while a low nibble is held
  logic [NUM_PORTS-1:0] take_low;   // this nibble goes into the holding register
  logic [3:0]           held_nib [NUM_PORTS];
  logic [NUM_PORTS-1:0] held_er;

  // registered byte fields
  logic [NUM_PORTS-1:0] strobe_q;
  logic [NUM_PORTS-1:0] active_q;
  logic [NUM_PORTS-1:0] er_q;
  logic [7:0]           data_q   [NUM_PORTS];

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      // phase is cleared while rx_dv is low so a rising rx_dv starts a new pair
      take_low[i] = rx_pins[i].rx_dv & ~phase[i];
    end
  end

  // phase, strobe and active level
  always_ff @(posedge clock) begin
    if (reset) begin
      phase    <= '0;
      strobe_q <= '0;
      active_q <= '0;
    end else begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        active_q[i] <= rx_pins[i].rx_dv;
        // half byte left when rx_dv drops is simply lost
        phase[i]    <= take_low[i];
        strobe_q[i] <= rx_pins[i].rx_dv & ~take_low[i];
      end
    end
  end

  // held low nibble and assembled byte
  always_ff @(posedge clock) begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (take_low[i]) begin
        held_nib[i] <= rx_pins[i].rxd;
        held_er[i]  <= rx_pins[i].rx_er;
      end
      data_q[i] <= {rx_pins[i].rxd, held_nib[i]};
      er_q[i]   <= held_er[i] | rx_pins[i].rx_er;
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      byte_bus[i].strobe = strobe_q[i];
      byte_bus[i].active = active_q[i];
      byte_bus[i].er     = er_q[i];
      byte_bus[i].data   = data_q[i];
    end
  end

endmodule

// ==== design/sfd_frame_detect.sv ====
// sfd_frame_detect: preamble counter, sfd match and payload / end beat generation for one lane
module sfd_frame_detect #(
  parameter int MIN_PREAMBLE = 5
) (
  input  logic                     clock,
  input  logic                     reset,
  input  rgmii_rx_pkg::rx_byte_t   in_byte,
  output rgmii_rx_pkg::lane_beat_t beat
);
  import rgmii_rx_pkg::*;

  localparam int               CNT_W    = $clog2(MIN_PREAMBLE + 1);
  localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(MIN_PREAMBLE);

  // ------------------------------------------------
  // state
  // ------------------------------------------------
  detect_state_e    state;
  logic [CNT_W-1:0] pre_cnt;     // 0x55 bytes still needed before the sfd
  logic             err_seen;    // sticky rx_er over the payload

  logic             data_hit;
  logic             end_hit;
  logic             sfd_hit;

  logic             beat_valid;
  beat_kind_e       beat_kind;
  logic [7:0]       beat_data;

  always_comb begin
    data_hit = (state == DET_PAYLOAD) && in_byte.active && in_byte.strobe;
    // active low while in payload means rx_dv just fell
    end_hit  = (state == DET_PAYLOAD) && !in_byte.active;
    sfd_hit  = (state == DET_PREAMBLE) && in_byte.active && in_byte.strobe &&
               (in_byte.data == 8'hd5) && (pre_cnt == '0);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= DET_IDLE;
      pre_cnt    <= CNT_LOAD;
      err_seen   <= 1'b0;
      beat_valid <= 1'b0;
    end else begin
      beat_valid <= data_hit | end_hit;
      case (state)
        DET_IDLE: begin
          pre_cnt <= CNT_LOAD;
          // first strobe comes a cycle after active at the earliest
          if (in_byte.active) state <= DET_PREAMBLE;
        end
        DET_PREAMBLE: begin
          if (!in_byte.active) begin
            // short or broken preamble, nothing emitted
            state <= DET_IDLE;
          end else if (sfd_hit) begin
            state    <= DET_PAYLOAD;
            err_seen <= 1'b0;
          end else if (in_byte.strobe) begin
            if (in_byte.data == 8'h55) begin
              if (pre_cnt != '0) pre_cnt <= pre_cnt - 1'b1;
            end else begin
              // wrong byte, start counting again
              pre_cnt <= CNT_LOAD;
            end
          end
        end
        DET_PAYLOAD: begin
          if (end_hit) state <= DET_IDLE;
          else if (data_hit && in_byte.er) err_seen <= 1'b1;
        end
        default: state <= DET_IDLE;
      endcase
    end
  end

  // ------------------------------------------------
  // beat payload
  // ------------------------------------------------
  always_ff @(posedge clock) begin
    if (end_hit) beat_kind <= err_seen ? BEAT_END_ERR : BEAT_END_OK;
    else beat_kind <= BEAT_DATA;
    beat_data <= in_byte.data;
  end

  always_comb begin
    beat.valid = beat_valid;
    beat.kind  = beat_kind;
    beat.data  = beat_data;
  end

endmodule

// ==== design/frame_merger.sv ====
// frame_merger: locks onto one lane's frame, forwards it tagged with the port, drops and counts the rest
module frame_merger #(
  parameter int NUM_PORTS = 4
) (
  input  logic                     clock,
  input  logic                     reset,
  input  rgmii_rx_pkg::lane_beat_t lane_bus [NUM_PORTS],
  output rgmii_rx_pkg::hub_beat_t  out,
  output logic [15:0]              drop_count
);
  import rgmii_rx_pkg::*;

  // ------------------------------------------------
  // state
  // ------------------------------------------------
  merge_state_e         state;
  logic [PORT_ID_W-1:0] locked;
  logic [NUM_PORTS-1:0] dropping;   // lane's current frame is being thrown away

  logic [NUM_PORTS-1:0] start;
  logic [NUM_PORTS-1:0] drop_now;
  logic [NUM_PORTS-1:0] end_seen;
  logic                 win_found;
  logic [PORT_ID_W-1:0] win_port;
  logic [PORT_ID_W-1:0] sel_port;
  lane_beat_t           fwd;
  logic                 fwd_go;
  logic [3:0]           drop_n;
  logic [16:0]          drop_sum;

  logic                 out_valid;
  beat_kind_e           out_kind;
  logic [PORT_ID_W-1:0] out_port;
  logic [7:0]           out_data;

  // start detect and priority pick, lowest lane wins
  always_comb begin
    win_found = 1'b0;
    win_port  = '0;
    drop_now  = '0;
    drop_n    = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      start[i] = lane_bus[i].valid && (lane_bus[i].kind == BEAT_DATA) && !dropping[i] &&
                 !((state == MRG_FORWARD) && (locked == PORT_ID_W'(i)));
      end_seen[i] = lane_bus[i].valid && (lane_bus[i].kind != BEAT_DATA);
      if (start[i]) begin
        if ((state == MRG_IDLE) && !win_found) begin
          win_found = 1'b1;
          win_port  = PORT_ID_W'(i);
        end else begin
          drop_now[i] = 1'b1;
          drop_n      = drop_n + 4'd1;
        end
      end
    end
  end

  // beat selection, from the winner when idle, else from the locked lane
  always_comb begin
    sel_port = (state == MRG_IDLE) ? win_port : locked;
    fwd      = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (sel_port == PORT_ID_W'(i)) fwd = lane_bus[i];
    end
    fwd_go   = (state == MRG_IDLE) ? win_found : fwd.valid;
    drop_sum = {1'b0, drop_count} + 17'(drop_n);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= MRG_IDLE;
      locked     <= '0;
      dropping   <= '0;
      out_valid  <= 1'b0;
      drop_count <= '0;
    end else begin
      out_valid  <= fwd_go;
      // a dropped frame is ignored up to and including its end beat
      dropping   <= (dropping & ~end_seen) | drop_now;
      // saturate instead of wrapping
      drop_count <= drop_sum[16] ? 16'hffff : drop_sum[15:0];
      case (state)
        MRG_IDLE: begin
          if (win_found) begin
            locked <= win_port;
            state  <= MRG_FORWARD;
          end
        end
        MRG_FORWARD: begin
          if (fwd.valid && (fwd.kind != BEAT_DATA)) state <= MRG_IDLE;
        end
        default: state <= MRG_IDLE;
      endcase
    end
  end

  // output payload
  always_ff @(posedge clock) begin
    out_kind <= fwd.kind;
    out_port <= sel_port;
    out_data <= fwd.data;
  end

  always_comb begin
    out.valid = out_valid;
    out.kind  = out_kind;
    out.port  = out_port;
    out.data  = out_data;
  end

endmodule

// ==== design/rgmii_rx_hub.sv ====
// rgmii_rx_hub: top level with nibble capture, per-port sfd detectors and the frame merger
module rgmii_rx_hub #(
  parameter int NUM_PORTS    = 4,   // 1 to 8
  parameter int MIN_PREAMBLE = 5
) (
  input  logic                      clock,
  input  logic                      reset,
  input  rgmii_rx_pkg::rgmii_pins_t rx_pins [NUM_PORTS],
  output rgmii_rx_pkg::hub_beat_t   out,
  output logic [15:0]               drop_count
);
  import rgmii_rx_pkg::*;

  // ------------------------------------------------
  // internal buses
  // ------------------------------------------------
  rx_byte_t   byte_bus [NUM_PORTS];   // capture to detectors
  lane_beat_t lane_bus [NUM_PORTS];   // detectors to merger

  // stage 1: nibbles to bytes
  rgmii_nibble_capture #(
    .NUM_PORTS (NUM_PORTS)
  ) u_capture (
    .clock    (clock),
    .reset    (reset),
    .rx_pins  (rx_pins),
    .byte_bus (byte_bus)
  );

  // stage 2: one preamble / sfd detector per port
  for (genvar i = 0; i < NUM_PORTS; i++) begin : u_detect
    sfd_frame_detect #(
      .MIN_PREAMBLE (MIN_PREAMBLE)
    ) u_sfd (
      .clock   (clock),
      .reset   (reset),
      .in_byte (byte_bus[i]),
      .beat    (lane_bus[i])
    );
  end

  // stage 3: one frame at a time onto the output
  frame_merger #(
    .NUM_PORTS (NUM_PORTS)
  ) u_merge (
    .clock      (clock),
    .reset      (reset),
    .lane_bus   (lane_bus),
    .out        (out),
    .drop_count (drop_count)
  );

endmodule

// ==== bench/rgmii_rx_hub_props.sv ====
// rgmii_rx_hub_props: pin history, open-frame tracker and concurrent checks on the hub outputs
module rgmii_rx_hub_props #(
  parameter int NUM_PORTS = 4
) (
  input logic                      clock,
  input logic                      reset,
  input rgmii_rx_pkg::rgmii_pins_t rx_pins [NUM_PORTS],
  input rgmii_rx_pkg::hub_beat_t   out,
  input logic [15:0]               drop_count
);
  timeunit 1ns;
  timeprecision 100ps;
  import rgmii_rx_pkg::*;

  // --------------------------------------------------
  // trackers
  // --------------------------------------------------
  rgmii_pins_t          past_pins [NUM_PORTS][4];   // [0] one sample back, [3] four back
  logic                 open;        // a frame is on the output
  logic [PORT_ID_W-1:0] open_port;
  logic                 open_err;    // rx_er on its pins after the sfd
  logic [7:0]           exp_data;
  logic                 exp_dv;
  logic                 first_err;
  logic                 next_err;
  int                   fail_count = 0;

  always_comb begin
    exp_data  = '0;
    exp_dv    = 1'b0;
    first_err = 1'b0;
    next_err  = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (out.port == PORT_ID_W'(p)) begin
        // high nibble three samples back, low nibble four back
        exp_data  = {past_pins[p][2].rxd, past_pins[p][3].rxd};
        exp_dv    = past_pins[p][2].rx_dv & past_pins[p][3].rx_dv;
        // payload from its first low nibble up to the current sample
        first_err = rx_pins[p].rx_dv & rx_pins[p].rx_er;
        for (int j = 0; j < 4; j++) begin
          first_err = first_err | (past_pins[p][j].rx_dv & past_pins[p][j].rx_er);
        end
      end
      if (open_port == PORT_ID_W'(p)) begin
        next_err = rx_pins[p].rx_dv & rx_pins[p].rx_er;
      end
    end
  end

  always @(posedge clock) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      past_pins[p][0] <= rx_pins[p];
      for (int j = 1; j < 4; j++) begin
        past_pins[p][j] <= past_pins[p][j-1];
      end
    end
    if (reset) begin
      open      <= 1'b0;
      open_port <= '0;
      open_err  <= 1'b0;
    end else if (out.valid && out.kind == BEAT_DATA && !open) begin
      open      <= 1'b1;
      open_port <= out.port;
      open_err  <= first_err;
    end else if (out.valid && out.kind != BEAT_DATA) begin
      open <= 1'b0;
    end else if (open) begin
      open_err <= open_err | next_err;
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  assert property (@(posedge clock) reset |=> !out.valid && drop_count == 16'd0)
    else begin
      fail_count++;
      $error("ERR %0t: output beat or dropped frames during reset", $time);
    end

  assert property (@(posedge clock) disable iff (reset)
    out.valid && out.kind == BEAT_DATA |-> out.data == exp_data && exp_dv)
    else begin
      fail_count++;
      $error("ERR %0t: port %0d data %h, pins gave %h", $time, out.port, out.data, exp_data);
    end

  // one frame at a time on the output
  assert property (@(posedge clock) disable iff (reset)
    out.valid && open |-> out.port == open_port)
    else begin
      fail_count++;
      $error("ERR %0t: beat from port %0d inside frame of port %0d", $time, out.port, open_port);
    end

  assert property (@(posedge clock) disable iff (reset)
    out.valid && out.kind != BEAT_DATA |->
      open && out.kind == (open_err ? BEAT_END_ERR : BEAT_END_OK))
    else begin
      fail_count++;
      $error("ERR %0t: end beat kind %0d, open %0b, rx_er seen %0b", $time, out.kind, open,
             open_err);
    end

  assert property (@(posedge clock) disable iff (reset)
    !reset |=> drop_count >= $past(drop_count))
    else begin
      fail_count++;
      $error("ERR %0t: drop count fell to %0d", $time, drop_count);
    end

endmodule

bind rgmii_rx_hub rgmii_rx_hub_props #(
  .NUM_PORTS (NUM_PORTS)
) u_props (.*);

// ==== bench/rgmii_rx_hub_tb.sv ====
// rgmii_rx_hub_tb: clock and reset, scheduled and random frame stimulus, beat totals and result
module rgmii_rx_hub_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import rgmii_rx_pkg::*;

  localparam int NUM_PORTS = 4;
  localparam int TIMEOUT   = 400;

  logic        clock;
  logic        reset;
  rgmii_pins_t rx_pins [NUM_PORTS];
  hub_beat_t   out;
  logic [15:0] drop_count;

  // totals from the output monitor indexed by the port field
  int data_count [8] = '{default: 0};
  int end_count  [8] = '{default: 0};
  int end_total = 0;
  int err_total = 0;
  int sent_valid = 0;   // frames sent with a preamble of 5 or more

  rgmii_rx_hub #(
    .NUM_PORTS    (NUM_PORTS),
    .MIN_PREAMBLE (5)
  ) u_dut (
    .clock      (clock),
    .reset      (reset),
    .rx_pins    (rx_pins),
    .out        (out),
    .drop_count (drop_count)
  );

  always #4 clock = ~clock;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_count(input string what, input int got, input int want);
    assert (got == want)
      else abort_run($sformatf("ERR %0t: %s is %0d, expected %0d", $time, what, got, want));
  endtask

  // --------------------------------------------------
  // output monitor
  // --------------------------------------------------
  always @(negedge clock) begin
    if (u_dut.u_props.fail_count != 0) begin
      abort_run("a concurrent property of the hub failed");
    end
    if (!reset && out.valid) begin
      assert (int'(out.port) < NUM_PORTS && out.kind inside {BEAT_DATA, BEAT_END_OK, BEAT_END_ERR})
        else abort_run($sformatf("ERR %0t: beat port %0d kind %0d", $time, out.port, out.kind));
      if (out.kind == BEAT_DATA) begin
        data_count[out.port]++;
      end else begin
        end_count[out.port]++;
        end_total++;
        if (out.kind == BEAT_END_ERR) err_total++;
      end
    end
  end

  // --------------------------------------------------
  // pin drivers
  // --------------------------------------------------
  // low nibble first on the falling edge
  task automatic send_byte(input int p, input logic [7:0] b, input logic er);
    @(negedge clock);
    rx_pins[p] = '{rxd: b[3:0], rx_dv: 1'b1, rx_er: er};
    @(negedge clock);
    rx_pins[p] = '{rxd: b[7:4], rx_dv: 1'b1, rx_er: 1'b0};
  endtask

  task automatic send_preamble(input int p, input int n);
    repeat (n) send_byte(p, 8'h55, 1'b0);
  endtask

  // er_byte of -1 keeps rx_er low for the whole payload
  task automatic send_payload(input int p, input int n, input int er_byte);
    for (int i = 0; i < n; i++) begin
      send_byte(p, 8'($urandom), i == er_byte);
    end
  endtask

  task automatic end_frame(input int p, input int gap);
    @(negedge clock);
    rx_pins[p] = '0;
    repeat (gap - 1) @(negedge clock);
  endtask

  task automatic send_frame(input int p, input int pre, input int pay, input int er_byte);
    send_preamble(p, pre);
    send_byte(p, 8'hd5, 1'b0);
    send_payload(p, pay, er_byte);
    end_frame(p, 6);
  endtask

  task automatic delayed_frame(input int p, input int dly, input int pre, input int pay,
                               input int er_byte);
    repeat (dly) @(negedge clock);
    send_frame(p, pre, pay, er_byte);
  endtask

  // frames either forwarded or dropped must reach the given total
  task automatic wait_for_totals(input int frames);
    int cycles;
    cycles = 0;
    while (end_total + int'(drop_count) != frames) begin
      @(posedge clock);
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run($sformatf("timed out waiting for %0d finished frames", frames));
      end
    end
  endtask

  initial begin
    int pre [NUM_PORTS];
    int pay [NUM_PORTS];
    int erb [NUM_PORTS];
    int dly [NUM_PORTS];
    clock = 1'b0;
    reset = 1'b1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      rx_pins[p] = '0;
    end
    void'($urandom(32'hd4be_b377));
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    // --------------------------------------------------
    // fixed schedule
    // --------------------------------------------------
    send_frame(0, 7, 8, -1);
    wait_for_totals(1);
    check_count("port 0 data beats", data_count[0], 8);
    check_count("error end beats", err_total, 0);
    // exact minimum preamble with rx_er on the third payload byte
    send_frame(3, 5, 5, 2);
    wait_for_totals(2);
    check_count("port 3 data beats", data_count[3], 5);
    check_count("error end beats", err_total, 1);
    // 4 preamble bytes are too few
    send_frame(1, 4, 6, -1);
    send_frame(1, 6, 6, -1);
    wait_for_totals(3);
    check_count("port 1 end beats", end_count[1], 1);
    check_count("port 1 data beats", data_count[1], 6);
    // wrong byte restarts the count and only 4 more 0x55 follow
    send_preamble(2, 3);
    send_byte(2, 8'h5a, 1'b0);
    send_preamble(2, 4);
    send_byte(2, 8'hd5, 1'b0);
    send_payload(2, 6, -1);
    end_frame(2, 6);
    send_frame(2, 5, 4, -1);
    wait_for_totals(4);
    check_count("port 2 end beats", end_count[2], 1);
    check_count("port 2 data beats", data_count[2], 4);
    // sfd on the same cycle for ports 1 and 2 where the lower port wins
    fork
      send_frame(1, 6, 7, -1);
      send_frame(2, 6, 7, -1);
    join
    wait_for_totals(6);
    check_count("dropped frames", int'(drop_count), 1);
    check_count("port 1 end beats", end_count[1], 2);
    check_count("port 2 end beats", end_count[2], 1);
    check_count("port 1 data beats", data_count[1], 13);
    sent_valid = 6;

    // --------------------------------------------------
    // random overlapping traffic on all ports
    // --------------------------------------------------
    for (int r = 0; r < 10; r++) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        dly[p] = $urandom_range(30);
        pre[p] = $urandom_range(8, 3);
        pay[p] = $urandom_range(16, 4);
        erb[p] = ($urandom_range(3) == 0) ? int'($urandom_range(pay[p] - 1)) : -1;
        if (pre[p] >= 5) sent_valid++;
      end
      fork
        delayed_frame(0, dly[0], pre[0], pay[0], erb[0]);
        delayed_frame(1, dly[1], pre[1], pay[1], erb[1]);
        delayed_frame(2, dly[2], pre[2], pay[2], erb[2]);
        delayed_frame(3, dly[3], pre[3], pay[3], erb[3]);
      join
    end
    // output plus dropped must match the frames sent with a valid preamble
    wait_for_totals(sent_valid);

    if (u_dut.u_props.fail_count == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      abort_run("a concurrent property of the hub failed at the end of the run");
    end
  end

endmodule

// ==== vlog.f ====
design/rgmii_rx_pkg.sv
design/rgmii_nibble_capture.sv
design/sfd_frame_detect.sv
design/frame_merger.sv
design/rgmii_rx_hub.sv
bench/rgmii_rx_hub_props.sv
bench/rgmii_rx_hub_tb.sv

// ==== Makefile ====
# Verilator build and run of the rgmii receive hub testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  -f vlog.f --top-module rgmii_rx_hub_tb -Mdir obj_dir -o rgmii_rx_hub_tb
	./obj_dir/rgmii_rx_hub_tb +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
